//--- all.f
+incdir+test
design/issue_pkg.sv
design/elastic_buffer.sv
design/inst_buffer.sv
design/scoreboard.sv
design/issue_stage.sv
test/issue_stage_tb.sv

//--- design/elastic_buffer.sv
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATA_W = 32,
    parameter int SIZE = 1,
    parameter bit OUT_REG = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    output logic              ready_in,
    input  logic [DATA_W-1:0] data_in,
    output logic              valid_out,
    input  logic              ready_out,
    output logic [DATA_W-1:0] data_out
);

    if (SIZE == 1) begin : g_pipe
        logic              valid_q;
        logic [DATA_W-1:0] data_q;

        // a full slot still takes a new word when the old one leaves this cycle
        assign ready_in = ~valid_q || ready_out;

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= 1'b0;
            end else if (ready_in) begin
                valid_q <= valid_in;
            end
        end

        always_ff @(posedge clk) begin
            if (ready_in && valid_in) begin
                data_q <= data_in;
            end
        end

        assign valid_out = valid_q;
        assign data_out = data_q;
    end else if (OUT_REG) begin : g_skid_reg
        logic              out_valid;
        logic [DATA_W-1:0] out_data;
        logic              skid_valid;
        logic [DATA_W-1:0] skid_data;
        logic              out_ready;

        assign out_ready = ~out_valid || ready_out;
        // ready_in comes straight from the skid flop so the upstream path is short
        assign ready_in = ~skid_valid;

        always_ff @(posedge clk) begin
            if (reset) begin
                out_valid <= 1'b0;
                skid_valid <= 1'b0;
            end else if (out_ready) begin
                out_valid <= skid_valid || valid_in;
                skid_valid <= 1'b0;
            end else if (valid_in && ready_in) begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (out_ready) begin
                out_data <= skid_valid ? skid_data : data_in;
            end else if (valid_in && ready_in) begin
                skid_data <= data_in;
            end
        end

        assign valid_out = out_valid;
        assign data_out = out_data;
    end else begin : g_skid_mux
        logic [DATA_W-1:0] entry [2];
        logic              wr_sel;
        logic              rd_sel;
        logic [1:0]        count;
        logic              push;
        logic              pop;

        assign ready_in = (count != 2'd2);
        assign valid_out = (count != 2'd0);
        assign push = valid_in && ready_in;
        assign pop = valid_out && ready_out;

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_sel <= 1'b0;
                rd_sel <= 1'b0;
                count <= 2'd0;
            end else begin
                if (push) begin
                    wr_sel <= ~wr_sel;
                end
                if (pop) begin
                    rd_sel <= ~rd_sel;
                end
                count <= count + 2'(push) - 2'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                entry[wr_sel] <= data_in;
            end
        end

        // output is muxed from the two entries, not taken from a flop
        assign data_out = entry[rd_sel];
    end

endmodule

//--- design/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import issue_pkg::*; #(
    parameter int DEPTH = 4,
    parameter int NUM_WARPS = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_valid,
    output logic  inst_ready,
    input  inst_t inst,
    output logic  sb_valid,
    input  logic  sb_ready,
    output inst_t sb_inst
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    // only the index bits of the configured warp count are kept
    localparam logic [warp_w-1:0] warp_mask = warp_w'(NUM_WARPS - 1);

    inst_t            mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;
    inst_t            wr_inst;

    assign inst_ready = (count != cnt_w'(DEPTH));
    assign sb_valid = (count != '0);
    assign push = inst_valid && inst_ready;
    assign pop = sb_valid && sb_ready;

    always_comb begin
        wr_inst = inst;
        wr_inst.warp = inst.warp & warp_mask;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_inst;
        end
    end

    // the head entry is read out of the register array, so a new word
    // shows up here one cycle after it was accepted
    assign sb_inst = mem[rd_ptr];

endmodule

//--- design/issue_pkg.sv
package issue_pkg;

    // register file geometry per warp
    localparam int reg_w = 5;
    localparam int num_regs = 32;

    // the warp index width is sized for the default of four warps
    localparam int warp_w = 2;

    // instruction tag, opcode and datapath widths
    localparam int uuid_w = 8;
    localparam int op_w = 4;
    localparam int xlen = 32;

    // in the register view of the last operand field rs3 sits in the low bits
    typedef struct packed {
        logic [xlen-reg_w-1:0] pad;
        logic [reg_w-1:0]      rs3;
    } rs3_view_t;

    // the last operand field is read as rs3 for R4 formats and as an immediate otherwise
    typedef union packed {
        rs3_view_t         reg_view;
        logic [xlen-1:0]   imm;
    } operand_u;

    typedef struct packed {
        logic [uuid_w-1:0] uuid;
        logic [warp_w-1:0] warp;
        logic [xlen-1:0]   pc;
        logic [op_w-1:0]   op;
        // set when the instruction writes rd
        logic              wb;
        logic [reg_w-1:0]  rd;
        logic [reg_w-1:0]  rs1;
        logic [reg_w-1:0]  rs2;
        // selects the rs3 view of ext
        logic              is_r4;
        operand_u          ext;
    } inst_t;

    localparam int inst_w = $bits(inst_t);

endpackage

//--- design/issue_stage.sv
`timescale 1ns/1ps

module issue_stage import issue_pkg::*; #(
    parameter int NUM_WARPS = 4,
    parameter int IBUF_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,

    // decoded instructions in
    input  logic              inst_valid,
    output logic              inst_ready,
    input  inst_t             inst,

    // writeback from the execute side
    input  logic              wb_valid,
    input  logic [warp_w-1:0] wb_warp,
    input  logic [reg_w-1:0]  wb_rd,
    input  logic              wb_eop,

    // hazard-free instructions out
    output logic              issue_valid,
    input  logic              issue_ready,
    output inst_t             issue_inst,

    output logic [31:0]       stall_cycles
);

    logic  sb_valid;
    logic  sb_ready;
    inst_t sb_inst;

    // decouples decode from issue and keeps program order
    inst_buffer #(
        .DEPTH     (IBUF_DEPTH),
        .NUM_WARPS (NUM_WARPS)
    ) inst_buffer_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .sb_valid   (sb_valid),
        .sb_ready   (sb_ready),
        .sb_inst    (sb_inst)
    );

    scoreboard #(
        .NUM_WARPS (NUM_WARPS)
    ) scoreboard_i (
        .clk          (clk),
        .reset        (reset),
        .sb_valid     (sb_valid),
        .sb_ready     (sb_ready),
        .sb_inst      (sb_inst),
        .wb_valid     (wb_valid),
        .wb_warp      (wb_warp),
        .wb_rd        (wb_rd),
        .wb_eop       (wb_eop),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_inst   (issue_inst),
        .stall_cycles (stall_cycles)
    );

endmodule

//--- design/scoreboard.sv
`timescale 1ns/1ps

module scoreboard import issue_pkg::*; #(
    parameter int NUM_WARPS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              sb_valid,
    output logic              sb_ready,
    input  inst_t             sb_inst,
    input  logic              wb_valid,
    input  logic [warp_w-1:0] wb_warp,
    input  logic [reg_w-1:0]  wb_rd,
    input  logic              wb_eop,
    output logic              issue_valid,
    input  logic              issue_ready,
    output inst_t             issue_inst,
    output logic [31:0]       stall_cycles
);

    // one outstanding-write bit per warp and register
    logic [NUM_WARPS-1:0][num_regs-1:0] inuse;
    logic [NUM_WARPS-1:0][num_regs-1:0] inuse_n;

    // ready bits of the staged instruction in the order {rd, rs1, rs2, rs3}
    logic [3:0] ready_mask;
    logic [3:0] ready_mask_n;

    logic  stg_valid;
    logic  stg_ready;
    inst_t stg_inst;
    logic  regs_ready;
    logic  out_valid_in;
    logic  out_ready_in;
    logic  wb_fire;
    logic  sb_fire;
    logic  stg_fire;

    // only the last beat of a writeback packet retires the register
    assign wb_fire = wb_valid && wb_eop;
    assign sb_fire = sb_valid && sb_ready;
    assign stg_fire = stg_valid && stg_ready;
    assign regs_ready = &ready_mask;

    always_comb begin
        inuse_n = inuse;
        ready_mask_n = ready_mask;

        if (wb_fire) begin
            inuse_n[wb_warp][wb_rd] = 1'b0;
            if (wb_warp == stg_inst.warp) begin
                ready_mask_n |= {wb_rd == stg_inst.rd,
                                 wb_rd == stg_inst.rs1,
                                 wb_rd == stg_inst.rs2,
                                 wb_rd == stg_inst.ext.reg_view.rs3};
            end
        end

        // the leaving instruction claims its destination before the next one looks
        if (stg_fire && stg_inst.wb) begin
            inuse_n[stg_inst.warp][stg_inst.rd] = 1'b1;
            ready_mask_n = '0;
        end

        // rd is forced ready without wb and rs3 is forced ready outside R4 format
        if (sb_fire) begin
            ready_mask_n = ~{inuse_n[sb_inst.warp][sb_inst.rd] & sb_inst.wb,
                             inuse_n[sb_inst.warp][sb_inst.rs1],
                             inuse_n[sb_inst.warp][sb_inst.rs2],
                             inuse_n[sb_inst.warp][sb_inst.ext.reg_view.rs3] & sb_inst.is_r4};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inuse <= '0;
            ready_mask <= '0;
        end else begin
            inuse <= inuse_n;
            ready_mask <= ready_mask_n;
        end
    end

    // the staging slot holds the instruction while its mask fills in
    elastic_buffer #(
        .DATA_W  (inst_w),
        .SIZE    (1),
        .OUT_REG (0)
    ) stg_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (sb_valid),
        .ready_in  (sb_ready),
        .data_in   (sb_inst),
        .valid_out (stg_valid),
        .ready_out (stg_ready),
        .data_out  (stg_inst)
    );

    assign out_valid_in = stg_valid && regs_ready;
    assign stg_ready = out_ready_in && regs_ready;

    // the issue side of the two-entry output buffer leaves from a flop
    elastic_buffer #(
        .DATA_W  (inst_w),
        .SIZE    (2),
        .OUT_REG (1)
    ) out_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (out_valid_in),
        .ready_in  (out_ready_in),
        .data_in   (stg_inst),
        .valid_out (issue_valid),
        .ready_out (issue_ready),
        .data_out  (issue_inst)
    );

    // cycles where a staged instruction waits on an outstanding write
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_cycles <= '0;
        end else if (stg_valid && !regs_ready) begin
            stall_cycles <= stall_cycles + 32'd1;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module issue_stage_tb -Mdir obj_dir
./obj_dir/Vissue_stage_tb

//--- test/issue_vectors.svh
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

// each row gives warp, op, rd, rs1, rs2, wb, is_r4, ext, writeback delay, eop split and the
// register of warp 0 that must still be busy when the row issues, or -1 for none
task automatic load_vectors();
    // the long write of r5 in warp 0 is passed by the next two rows
    set_row(0, 1, 5, 1, 2, 1, 0, 32'h0000_0010, 80, 0, -1);
    set_row(1, 2, 7, 5, 3, 1, 0, 32'h0000_0024, 4, 0, 5);
    // immediate whose low bits read as r5
    set_row(0, 3, 8, 9, 10, 1, 0, 32'hffff_ffe5, 6, 0, 5);
    set_row(0, 4, 11, 8, 12, 1, 0, 32'h0000_0007, 3, 0, -1);
    set_row(0, 5, 11, 1, 2, 1, 0, 32'h0000_0000, 5, 1, -1);
    // waits for the eop beat of the split writeback above
    set_row(0, 6, 0, 11, 3, 0, 0, 32'h0000_0abc, 0, 0, -1);
    set_row(1, 7, 12, 7, 7, 1, 1, 32'h0000_0007, 10, 1, -1);
    set_row(1, 8, 13, 2, 4, 1, 1, 32'h0000_000c, 2, 0, -1);
    set_row(2, 9, 3, 1, 2, 1, 0, 32'h0000_1234, 1, 0, -1);
    set_row(2, 1, 4, 3, 3, 1, 0, 32'h0000_0000, 2, 0, -1);
    set_row(3, 2, 31, 0, 0, 1, 1, 32'h0000_001e, 3, 0, -1);
    set_row(3, 3, 30, 31, 29, 1, 0, 32'h8000_0000, 7, 1, -1);
    set_row(3, 4, 0, 30, 31, 0, 1, 32'h0000_001e, 0, 0, -1);
    // rewrites r5 of warp 0 and so waits for the long write
    set_row(0, 5, 5, 0, 1, 1, 0, 32'h0000_0000, 2, 0, -1);
    set_row(0, 6, 6, 5, 6, 1, 0, 32'h0000_0055, 3, 0, -1);
    set_row(1, 7, 1, 13, 12, 1, 1, 32'h0000_0001, 4, 1, -1);
    set_row(2, 8, 9, 4, 3, 1, 0, 32'hdead_beef, 2, 0, -1);
    set_row(2, 9, 0, 9, 9, 0, 1, 32'h0000_0009, 0, 0, -1);
    set_row(3, 10, 2, 2, 2, 1, 1, 32'h0000_0002, 5, 0, -1);
    set_row(0, 11, 6, 6, 5, 1, 1, 32'h0000_0006, 1, 1, -1);
endtask

`endif

//--- test/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb import issue_pkg::*; ();

    localparam int num_warps = 4;
    // cycles between the non-eop beat and the eop beat of a split writeback
    localparam int split_gap = 6;

    logic              clk;
    logic              reset;
    logic              inst_valid;
    logic              inst_ready;
    inst_t             inst;
    logic              wb_valid;
    logic [warp_w-1:0] wb_warp;
    logic [reg_w-1:0]  wb_rd;
    logic              wb_eop;
    logic              issue_valid;
    logic              issue_ready;
    inst_t             issue_inst;
    logic [31:0]       stall_cycles;

    inst_t  vec_inst [$];
    int     vec_delay [$];
    bit     vec_split [$];
    int     vec_hold_reg [$];
    // reference in-use set of issued writers not yet retired by an eop beat
    bit     ref_busy [num_warps][num_regs];
    // writebacks waiting for their due cycle and the beats each still has to send
    int     pend_warp [$];
    int     pend_rd [$];
    int     pend_due [$];
    int     pend_beats [$];
    integer seed;
    int     cycle;
    int     cycle_limit;
    int     max_delay;
    int     row_ptr;
    int     issued;
    int     wb_idx;
    bit     held;
    inst_t  held_inst;

    issue_stage #(
        .NUM_WARPS  (num_warps),
        .IBUF_DEPTH (4)
    ) issue_stage_i (.*);

    task automatic fail_and_stop();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0h actual %0h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic set_row(input int w, op, rd, rs1, rs2, input bit wb, is_r4,
                           input logic [31:0] ext, input int delay, input bit split,
                           input int hold_reg);
        inst_t row;
        row = '0;
        row.uuid = uuid_w'(vec_inst.size());
        row.warp = warp_w'(w);
        row.pc = 32'h0000_1000 + 32'(4 * vec_inst.size());
        row.op = op_w'(op);
        row.wb = wb;
        row.rd = reg_w'(rd);
        row.rs1 = reg_w'(rs1);
        row.rs2 = reg_w'(rs2);
        row.is_r4 = is_r4;
        row.ext.imm = ext;
        vec_inst.push_back(row);
        vec_delay.push_back(delay);
        vec_split.push_back(split);
        vec_hold_reg.push_back(hold_reg);
    endtask

    `include "issue_vectors.svh"

    task automatic drive_inputs();
        inst_valid = (row_ptr < vec_inst.size());
        if (inst_valid) begin
            inst = vec_inst[row_ptr];
        end
        // ready is held high in every other phase of 64 cycles and random in between
        issue_ready = ((cycle / 64) % 2 == 1) || (($random(seed) & 3) != 0);
        wb_idx = -1;
        foreach (pend_due[i]) begin
            if (wb_idx < 0 && pend_due[i] <= cycle) begin
                wb_idx = i;
            end
        end
        wb_valid = (wb_idx >= 0);
        if (wb_valid) begin
            wb_warp = warp_w'(pend_warp[wb_idx]);
            wb_rd = reg_w'(pend_rd[wb_idx]);
            wb_eop = (pend_beats[wb_idx] == 1);
        end
    endtask

    task automatic check_issue();
        inst_t exp;
        string tag;
        exp = vec_inst[issued];
        tag = $sformatf("row %0d", issued);
        check_equal({tag, " rs3 view"}, exp.ext.reg_view.rs3, issue_inst.ext.reg_view.rs3);
        check_equal({tag, " imm view"}, exp.ext.imm, issue_inst.ext.imm);
        check_equal({tag, " word"}, exp, issue_inst);
        check_equal({tag, " rd busy"}, 0, exp.wb && ref_busy[exp.warp][exp.rd]);
        check_equal({tag, " rs1 busy"}, 0, ref_busy[exp.warp][exp.rs1]);
        check_equal({tag, " rs2 busy"}, 0, ref_busy[exp.warp][exp.rs2]);
        check_equal({tag, " rs3 busy"}, 0,
                    exp.is_r4 && ref_busy[exp.warp][exp.ext.reg_view.rs3]);
        // this row must get past a register of warp 0 that is still being written
        if (vec_hold_reg[issued] >= 0) begin
            check_equal({tag, " passed busy reg"}, 1, ref_busy[0][vec_hold_reg[issued]]);
        end
        if (exp.wb) begin
            ref_busy[exp.warp][exp.rd] = 1'b1;
            pend_warp.push_back(exp.warp);
            pend_rd.push_back(exp.rd);
            pend_due.push_back(cycle + vec_delay[issued] + ($random(seed) & 3));
            pend_beats.push_back(vec_split[issued] ? 2 : 1);
        end
        issued++;
    endtask

    task automatic sample_outputs();
        if (held) begin
            check_equal("held issue_valid", 1, issue_valid);
            check_equal("held issue_inst", held_inst, issue_inst);
        end
        held = issue_valid && !issue_ready;
        held_inst = issue_inst;
        // the issue check runs before this cycle's writeback clears the reference
        if (issue_valid && issue_ready) begin
            check_issue();
        end
        if (inst_valid && inst_ready) begin
            row_ptr++;
        end
        if (wb_valid && wb_eop) begin
            ref_busy[pend_warp[wb_idx]][pend_rd[wb_idx]] = 1'b0;
            pend_warp.delete(wb_idx);
            pend_rd.delete(wb_idx);
            pend_due.delete(wb_idx);
            pend_beats.delete(wb_idx);
        end else if (wb_valid) begin
            pend_beats[wb_idx] = 1;
            pend_due[wb_idx] = cycle + split_gap;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        seed = 32'h2cda;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        wb_valid = 1'b0;
        wb_warp = '0;
        wb_rd = '0;
        wb_eop = 1'b0;
        issue_ready = 1'b0;
        cycle = 0;
        row_ptr = 0;
        issued = 0;
        held = 1'b0;
        held_inst = '0;
        load_vectors();
        max_delay = 1;
        foreach (vec_delay[i]) begin
            if (vec_delay[i] > max_delay) begin
                max_delay = vec_delay[i];
            end
        end
        cycle_limit = vec_inst.size() * max_delay + 200;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_equal("reset inst_ready", 1, inst_ready);
        check_equal("reset issue_valid", 0, issue_valid);
        check_equal("reset sb_valid", 0, issue_stage_i.sb_valid);
        check_equal("reset in-use table", 0, issue_stage_i.scoreboard_i.inuse);
        check_equal("reset stall_cycles", 0, stall_cycles);
        while (issued < vec_inst.size()) begin
            @(posedge clk);
            #2;
            cycle++;
            if (cycle > cycle_limit) begin
                $display("timeout after %0d cycles, only %0d of %0d rows issued",
                         cycle, issued, vec_inst.size());
                fail_and_stop();
            end else begin
                drive_inputs();
                @(negedge clk);
                sample_outputs();
            end
        end
        // the table holds hazards, so some staged instruction had to wait
        check_equal("stall_cycles nonzero", 1, stall_cycles != 0);
        $display(">>> PASS");
        $finish;
    end

endmodule
